/* filelist.f */
+incdir+logic
logic/rv_pkg.sv
logic/alu.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_ctrl.sv
logic/exec_core.sv
bench/exec_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the exec_core testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_core_tb \
    -f filelist.f -o exec_core_sim \
    && ./obj_dir/exec_core_sim | tee /dev/stderr | grep -qx "All checks passed" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

/* bench/exec_core_tb.sv */
`default_nettype none

`include "core_params.svh"

module exec_core_tb
    import rv_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_INSTS       = 60;
    localparam int CYCLES_PER_INST = 6;
    localparam int MAX_CYCLES      = MAX_INSTS * CYCLES_PER_INST + 50;

    logic        clk;
    logic        rst;
    logic        inst_req;
    inst_t       inst_word;
    logic [31:0] inst_pc;
    logic        inst_ack;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [31:0] commit_next_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_wdata;
    logic        commit_wen;

    // reference model state
    logic [31:0] model_regs [32];
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] pc;
    logic [31:0] rng;

    // expected commit record of the instruction in flight
    logic [31:0] exp_pc;
    logic [31:0] exp_next_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    logic        exp_wen;

    int err_count;
    int cycle_count;

    logic [9:0] r_ops [8] = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
                              10'b0000000_110, 10'b0000000_100, 10'b0000000_010,
                              10'b0000000_001, 10'b0000000_101};
    logic [2:0] i_ops [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

    exec_core i_exec_core (
        .clk(clk), .rst(rst),
        .inst_req(inst_req), .inst_word(inst_word), .inst_pc(inst_pc),
        .inst_ack(inst_ack),
        .commit_valid(commit_valid), .commit_pc(commit_pc),
        .commit_next_pc(commit_next_pc), .commit_rd(commit_rd),
        .commit_wdata(commit_wdata), .commit_wen(commit_wen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        err_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            report_error("timeout, the handshake stopped making progress");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm12);
        return {imm12, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] csr_word(input logic [2:0] funct3, input logic [4:0] rd,
                                             input logic [11:0] csr, input logic [4:0] rs1);
        return {csr, rs1, funct3, rd, 7'b1110011};
    endfunction

    // integer result by funct3 with sub selectable on 000
    function automatic logic [31:0] ref_result(input logic [2:0] funct3, input logic sub,
                                               input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] csr_value(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS:   return m_mstatus;
            `CSR_MTVEC:     return m_mtvec;
            `CSR_MEPC:      return m_mepc;
            `CSR_MCAUSE:    return m_mcause;
            `CSR_MVENDORID: return `MVENDORID_VAL;
            `CSR_MARCHID:   return `MARCHID_VAL;
            default:        return 32'h0;
        endcase
    endfunction

    task automatic csr_store(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            `CSR_MSTATUS: m_mstatus = value;
            `CSR_MTVEC:   m_mtvec = value;
            `CSR_MEPC:    m_mepc = value;
            `CSR_MCAUSE:  m_mcause = value;
            default: ; // id registers are read only
        endcase
    endtask

    task automatic take_trap(input logic [31:0] cause, input logic [31:0] cur_pc);
        m_mepc = cur_pc;
        m_mcause = cause;
        m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
        m_mstatus[`MSTATUS_MIE_BIT] = 1'b0;
        exp_next_pc = m_mtvec;
    endtask

    task automatic step_model(input logic [31:0] word, input logic [31:0] cur_pc);
        logic [6:0]  funct7;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm12;
        logic [31:0] a;
        logic [31:0] result;
        logic [31:0] old_csr;
        logic        legal;
        logic        writes_rd;
        funct7 = word[31:25];
        funct3 = word[14:12];
        rd = word[11:7];
        rs1 = word[19:15];
        imm12 = word[31:20];
        a = model_regs[rs1];
        result = 32'h0;
        legal = 1'b1;
        writes_rd = 1'b0;
        exp_pc = cur_pc;
        exp_next_pc = cur_pc + 32'd4;
        exp_rd = rd;
        exp_wen = 1'b0;
        exp_wdata = 32'h0;
        case (word[6:0])
            7'b0110011: begin
                legal = ((funct7 == 7'b0) && (funct3 != 3'b011)) ||
                        (funct7 == 7'b0100000 && funct3 == 3'b000);
                result = ref_result(funct3, funct7[5], a, model_regs[word[24:20]]);
                writes_rd = 1'b1;
            end
            7'b0010011: begin
                legal = (funct3 != 3'b001) && (funct3 != 3'b011) && (funct3 != 3'b101);
                result = ref_result(funct3, 1'b0, a, {{20{imm12[11]}}, imm12});
                writes_rd = 1'b1;
            end
            7'b1110011: begin
                if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    old_csr = csr_value(imm12);
                    if (funct3 == 3'b001)
                        csr_store(imm12, a);
                    else if (rs1 != 5'd0)
                        csr_store(imm12, old_csr | a);
                    result = old_csr;
                    writes_rd = 1'b1;
                end else if (word == 32'h0000_0073) begin
                    take_trap(`CAUSE_ECALL_M, cur_pc);
                end else if (word == 32'h3020_0073) begin
                    exp_next_pc = m_mepc; // mret
                    m_mstatus[`MSTATUS_MIE_BIT] = m_mstatus[`MSTATUS_MPIE_BIT];
                    m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            take_trap(`CAUSE_ILLEGAL, cur_pc);
        end else if (writes_rd && rd != 5'd0) begin
            model_regs[rd] = result;
            exp_wen = 1'b1;
            exp_wdata = result;
        end
    endtask

    // four-phase transfer with req held for hold extra cycles after ack
    task automatic send_inst(input logic [31:0] word, input int hold);
        step_model(word, pc);
        while (inst_ack)
            @(negedge clk);
        inst_word = word;
        inst_pc = pc;
        inst_req = 1'b1;
        @(negedge clk);
        while (!inst_ack)
            @(negedge clk);
        repeat (hold) @(negedge clk);
        inst_req = 1'b0;
        @(negedge clk);
        while (inst_ack)
            @(negedge clk);
        pc = exp_next_pc;
    endtask

    // 32-bit constant in 11 + 11 + 10 bit chunks with x31 holding 11 and x30 holding 10
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        send_inst(i_word(3'b000, rd, 5'd0, {1'b0, value[31:21]}), 0);
        send_inst(r_word(7'd0, 3'b001, rd, rd, 5'd31), 0);
        send_inst(i_word(3'b110, rd, rd, {1'b0, value[20:10]}), 0);
        send_inst(r_word(7'd0, 3'b001, rd, rd, 5'd30), 0);
        send_inst(i_word(3'b110, rd, rd, {2'b0, value[9:0]}), 0);
    endtask

    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $past(inst_req && !inst_ack) |-> inst_ack)
        else report_error("inst_ack did not rise one cycle after inst_req");
    a_ack_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_ack) |-> $past(inst_req))
        else report_error("inst_ack rose without a request");
    a_ack_hold: assert property (@(posedge clk) disable iff (rst)
        $past(inst_ack && inst_req) |-> inst_ack)
        else report_error("inst_ack dropped while inst_req was still high");
    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $past(inst_ack && !inst_req) |-> !inst_ack)
        else report_error("inst_ack did not fall one cycle after inst_req dropped");
    a_commit_pulse: assert property (@(posedge clk) disable iff (rst)
        commit_valid == $rose(inst_ack))
        else report_error($sformatf("commit_valid %0b out of step with inst_ack", commit_valid));

    a_commit_pc: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_pc == exp_pc)
        else report_error($sformatf("commit_pc %h, expected %h", commit_pc, exp_pc));
    a_commit_next_pc: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_next_pc == exp_next_pc)
        else report_error($sformatf("commit_next_pc %h, expected %h at pc %h",
                                    commit_next_pc, exp_next_pc, exp_pc));
    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd == exp_rd)
        else report_error($sformatf("commit_rd %0d, expected %0d", commit_rd, exp_rd));
    a_commit_wen: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_wen == exp_wen)
        else report_error($sformatf("commit_wen %0b, expected %0b at pc %h",
                                    commit_wen, exp_wen, exp_pc));
    a_commit_wdata: assert property (@(posedge clk) disable iff (rst)
        commit_valid && exp_wen |-> commit_wdata == exp_wdata)
        else report_error($sformatf("commit_wdata %h, expected %h at pc %h",
                                    commit_wdata, exp_wdata, exp_pc));

    initial begin
        rst = 1'b1;
        inst_req = 1'b0;
        inst_word = 32'h0;
        inst_pc = 32'h0;
        err_count = 0;
        cycle_count = 0;
        rng = 32'd36;
        pc = 32'h0000_1000;
        m_mstatus = 32'h0;
        m_mtvec = 32'h0;
        m_mepc = 32'h0;
        m_mcause = 32'h0;
        for (int k = 0; k < 32; k++)
            model_regs[k] = 32'h0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!inst_ack && !commit_valid && !commit_wen)
            else report_error("inst_ack or commit outputs high after reset");

        send_inst(i_word(3'b000, 5'd31, 5'd0, 12'd11), 0);
        send_inst(i_word(3'b000, 5'd30, 5'd0, 12'd10), 0);
        for (int r = 1; r < 4; r++) begin
            rng = xorshift32(rng);
            load_reg(5'(r), rng);
        end

        for (int k = 0; k < 8; k++)
            send_inst(r_word(r_ops[k][9:3], r_ops[k][2:0], 5'(8 + k), 5'd1, 5'd2), 0);
        for (int k = 0; k < 5; k++) begin
            rng = xorshift32(rng);
            send_inst(i_word(i_ops[k], 5'(16 + k), 5'd1, rng[11:0]), 0);
        end

        send_inst(i_word(3'b000, 5'd0, 5'd1, 12'd5), 0); // write to x0
        send_inst(r_word(7'd0, 3'b000, 5'd21, 5'd0, 5'd0), 0);

        send_inst(csr_word(3'b001, 5'd0, `CSR_MTVEC, 5'd3), 0);
        send_inst(csr_word(3'b010, 5'd22, `CSR_MTVEC, 5'd0), 0);
        send_inst(csr_word(3'b010, 5'd23, `CSR_MVENDORID, 5'd0), 0);
        send_inst(csr_word(3'b010, 5'd24, `CSR_MARCHID, 5'd0), 0);
        send_inst(csr_word(3'b001, 5'd25, `CSR_MVENDORID, 5'd1), 0);
        send_inst(csr_word(3'b010, 5'd25, `CSR_MVENDORID, 5'd0), 0);
        send_inst(i_word(3'b000, 5'd26, 5'd0, 12'd8), 0);
        send_inst(csr_word(3'b010, 5'd0, `CSR_MSTATUS, 5'd26), 0); // set MIE
        send_inst(csr_word(3'b010, 5'd27, `CSR_MSTATUS, 5'd0), 0);
        send_inst(csr_word(3'b010, 5'd28, `CSR_MTVEC, 5'd1), 0);
        send_inst(csr_word(3'b010, 5'd29, `CSR_MTVEC, 5'd0), 0);

        send_inst(32'h0000_0073, 0); // ecall
        send_inst(csr_word(3'b010, 5'd4, `CSR_MEPC, 5'd0), 0);
        send_inst(csr_word(3'b010, 5'd5, `CSR_MCAUSE, 5'd0), 0);
        send_inst(csr_word(3'b010, 5'd6, `CSR_MSTATUS, 5'd0), 0);
        send_inst(32'h3020_0073, 0); // mret
        send_inst(csr_word(3'b010, 5'd7, `CSR_MSTATUS, 5'd0), 0);

        send_inst(32'hffff_ffff, 0);
        send_inst(csr_word(3'b010, 5'd4, `CSR_MCAUSE, 5'd0), 0);
        send_inst(r_word(7'b0100000, 3'b101, 5'd18, 5'd1, 5'd2), 0); // sra
        send_inst(i_word(3'b001, 5'd19, 5'd1, 12'd3), 0); // slli
        send_inst(csr_word(3'b010, 5'd5, `CSR_MEPC, 5'd0), 0);

        send_inst(r_word(7'd0, 3'b000, 5'd9, 5'd1, 5'd2), 3); // req held past ack

        if (err_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* logic/exec_core.sv */
`default_nettype none

`include "core_params.svh"

module exec_core
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_req,
    input  inst_t                  inst_word,
    input  logic [`XLEN-1:0]       inst_pc,
    output logic                   inst_ack,
    output logic                   commit_valid,
    output logic [`XLEN-1:0]       commit_pc,
    output logic [`XLEN-1:0]       commit_next_pc,
    output logic [`REG_ADDR_W-1:0] commit_rd,
    output logic [`XLEN-1:0]       commit_wdata,
    output logic                   commit_wen
);

    logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       rs1_val, rs2_val, imm, alu_b, alu_y, rd_data;
    logic [`XLEN-1:0]       csr_rdata, csr_wdata;
    logic [`XLEN-1:0]       mtvec, mepc, mstatus;
    alu_op_t                alu_op;
    wb_sel_t                wb_sel;
    sys_op_t                sys_op;
    logic                   use_imm, rf_we_int, csr_we_int;
    logic                   wen, csr_wen, mstatus_wen;
    logic [`CSR_ADDR_W-1:0] csr_waddr1, csr_waddr2;
    logic [`XLEN-1:0]       csr_wdata1, csr_wdata2, mstatus_wdata;

    assign alu_b   = use_imm ? imm : rs2_val;
    assign rd_data = (wb_sel == WB_CSR) ? csr_rdata : alu_y; // old csr value for csr ops

    inst_decoder i_inst_decoder (
        .inst(inst_word), .rs1_val(rs1_val), .csr_rdata(csr_rdata),
        .rs1(rs1), .rs2(rs2), .rd(rd), .csr_addr(csr_addr),
        .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .wb_sel(wb_sel),
        .rf_we_int(rf_we_int), .csr_we_int(csr_we_int),
        .csr_wdata(csr_wdata), .sys_op(sys_op)
    );

    alu i_alu (
        .op(alu_op), .a(rs1_val), .b(alu_b), .y(alu_y)
    );

    reg_file i_reg_file (
        .clk(clk), .rst(rst),
        .wen(wen), .waddr(rd), .wdata(rd_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_val), .rdata2(rs2_val),
        .csr_wen(csr_wen),
        .csr_waddr1(csr_waddr1), .csr_wdata1(csr_wdata1),
        .csr_waddr2(csr_waddr2), .csr_wdata2(csr_wdata2),
        .mstatus_wen(mstatus_wen), .mstatus_wdata(mstatus_wdata),
        .csr_raddr(csr_addr), .csr_rdata(csr_rdata),
        .mtvec(mtvec), .mepc(mepc), .mstatus(mstatus)
    );

    exec_ctrl i_exec_ctrl (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_pc(inst_pc),
        .sys_op(sys_op), .rf_we_int(rf_we_int), .csr_we_int(csr_we_int),
        .rd(rd), .csr_addr(csr_addr), .csr_wdata(csr_wdata), .rd_data(rd_data),
        .mtvec(mtvec), .mepc(mepc), .mstatus(mstatus),
        .inst_ack(inst_ack), .wen(wen), .csr_wen(csr_wen),
        .csr_waddr1(csr_waddr1), .csr_wdata1(csr_wdata1),
        .csr_waddr2(csr_waddr2), .csr_wdata2(csr_wdata2),
        .mstatus_wen(mstatus_wen), .mstatus_wdata(mstatus_wdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc),
        .commit_next_pc(commit_next_pc), .commit_rd(commit_rd),
        .commit_wdata(commit_wdata), .commit_wen(commit_wen)
    );

endmodule

`default_nettype wire

/* logic/exec_ctrl.sv */
`default_nettype none

`include "core_params.svh"

module exec_ctrl
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_req,
    input  logic [`XLEN-1:0]       inst_pc,
    input  sys_op_t                sys_op,
    input  logic                   rf_we_int,
    input  logic                   csr_we_int,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`XLEN-1:0]       csr_wdata,
    input  logic [`XLEN-1:0]       rd_data,
    input  logic [`XLEN-1:0]       mtvec,
    input  logic [`XLEN-1:0]       mepc,
    input  logic [`XLEN-1:0]       mstatus,
    output logic                   inst_ack,
    output logic                   wen,
    output logic                   csr_wen,
    output logic [`CSR_ADDR_W-1:0] csr_waddr1,
    output logic [`XLEN-1:0]       csr_wdata1,
    output logic [`CSR_ADDR_W-1:0] csr_waddr2,
    output logic [`XLEN-1:0]       csr_wdata2,
    output logic                   mstatus_wen,
    output logic [`XLEN-1:0]       mstatus_wdata,
    output logic                   commit_valid,
    output logic [`XLEN-1:0]       commit_pc,
    output logic [`XLEN-1:0]       commit_next_pc,
    output logic [`REG_ADDR_W-1:0] commit_rd,
    output logic [`XLEN-1:0]       commit_wdata,
    output logic                   commit_wen
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_ACK  = 1'b1;

    logic             state;
    logic             fire;
    logic             trap;
    logic             is_mret;
    logic [`XLEN-1:0] trap_cause;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] mstatus_trap;
    logic [`XLEN-1:0] mstatus_ret;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (inst_req) state <= ST_ACK;
                ST_ACK:  if (!inst_req) state <= ST_IDLE; // wait for req release
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign inst_ack = (state == ST_ACK);
    assign fire     = (state == ST_IDLE) && inst_req;

    assign trap       = (sys_op == SYS_ECALL) || (sys_op == SYS_ILLEGAL);
    assign is_mret    = (sys_op == SYS_MRET);
    assign trap_cause = (sys_op == SYS_ECALL) ? `CAUSE_ECALL_M : `CAUSE_ILLEGAL;

    always_comb begin
        mstatus_trap = mstatus;
        mstatus_trap[`MSTATUS_MPIE_BIT] = mstatus[`MSTATUS_MIE_BIT];
        mstatus_trap[`MSTATUS_MIE_BIT]  = 1'b0;
        mstatus_ret = mstatus;
        mstatus_ret[`MSTATUS_MIE_BIT]  = mstatus[`MSTATUS_MPIE_BIT];
        mstatus_ret[`MSTATUS_MPIE_BIT] = 1'b1;
    end

    assign wen     = fire && rf_we_int;
    assign csr_wen = fire && (csr_we_int || trap);

    // trap: port 1 takes mepc, port 2 mcause; otherwise port 2 mirrors port 1
    assign csr_waddr1 = trap ? `CSR_MEPC : csr_addr;
    assign csr_wdata1 = trap ? inst_pc : csr_wdata;
    assign csr_waddr2 = trap ? `CSR_MCAUSE : csr_waddr1;
    assign csr_wdata2 = trap ? trap_cause : csr_wdata1;

    assign mstatus_wen   = fire && (trap || is_mret ||
                                    (csr_we_int && csr_addr == `CSR_MSTATUS));
    assign mstatus_wdata = trap ? mstatus_trap : (is_mret ? mstatus_ret : csr_wdata);

    assign next_pc = trap ? mtvec : (is_mret ? mepc : inst_pc + `XLEN'd4);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
        end else begin
            commit_valid <= fire;
            commit_wen   <= wen && (rd != '0); // x0 writes are not reported
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            commit_pc      <= inst_pc;
            commit_next_pc <= next_pc;
            commit_rd      <= rd;
            commit_wdata   <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

`include "core_params.svh"

module reg_file
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  logic                   csr_wen,
    input  logic [`CSR_ADDR_W-1:0] csr_waddr1,
    input  logic [`XLEN-1:0]       csr_wdata1,
    input  logic [`CSR_ADDR_W-1:0] csr_waddr2,
    input  logic [`XLEN-1:0]       csr_wdata2,
    input  logic                   mstatus_wen,
    input  logic [`XLEN-1:0]       mstatus_wdata,
    input  logic [`CSR_ADDR_W-1:0] csr_raddr,
    output logic [`XLEN-1:0]       csr_rdata,
    output logic [`XLEN-1:0]       mtvec,
    output logic [`XLEN-1:0]       mepc,
    output logic [`XLEN-1:0]       mstatus
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mvendorid;
    logic [`XLEN-1:0] marchid;

    logic hit1_mtvec, hit2_mtvec;
    logic hit1_mepc, hit2_mepc;
    logic hit1_mcause, hit2_mcause;

    always_ff @(posedge clk) begin
        if (wen && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    assign hit1_mtvec  = (csr_waddr1 == `CSR_MTVEC);
    assign hit2_mtvec  = (csr_waddr2 == `CSR_MTVEC);
    assign hit1_mepc   = (csr_waddr1 == `CSR_MEPC);
    assign hit2_mepc   = (csr_waddr2 == `CSR_MEPC);
    assign hit1_mcause = (csr_waddr1 == `CSR_MCAUSE);
    assign hit2_mcause = (csr_waddr2 == `CSR_MCAUSE);

    // port 1 wins on a shared address
    always_ff @(posedge clk) begin
        if (csr_wen) begin
            if (hit1_mtvec)
                mtvec <= csr_wdata1;
            else if (hit2_mtvec)
                mtvec <= csr_wdata2;
            if (hit1_mepc)
                mepc <= csr_wdata1;
            else if (hit2_mepc)
                mepc <= csr_wdata2;
            if (hit1_mcause)
                mcause <= csr_wdata1;
            else if (hit2_mcause)
                mcause <= csr_wdata2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            mstatus <= '0;
        else if (mstatus_wen)
            mstatus <= mstatus_wdata;
    end

    // read-only ids
    always_ff @(posedge clk) begin
        if (rst) begin
            mvendorid <= `MVENDORID_VAL;
            marchid   <= `MARCHID_VAL;
        end
    end

    assign csr_rdata =
        ({`XLEN{csr_raddr == `CSR_MSTATUS}}   & mstatus)   |
        ({`XLEN{csr_raddr == `CSR_MTVEC}}     & mtvec)     |
        ({`XLEN{csr_raddr == `CSR_MEPC}}      & mepc)      |
        ({`XLEN{csr_raddr == `CSR_MCAUSE}}    & mcause)    |
        ({`XLEN{csr_raddr == `CSR_MVENDORID}} & mvendorid) |
        ({`XLEN{csr_raddr == `CSR_MARCHID}}   & marchid);

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`default_nettype none

`include "core_params.svh"

module inst_decoder
    import rv_pkg::*;
(
    input  inst_t                  inst,
    input  logic [`XLEN-1:0]       rs1_val,
    input  logic [`XLEN-1:0]       csr_rdata,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`CSR_ADDR_W-1:0] csr_addr,
    output alu_op_t                alu_op,
    output logic                   use_imm,
    output logic [`XLEN-1:0]       imm,
    output wb_sel_t                wb_sel,
    output logic                   rf_we_int,
    output logic                   csr_we_int,
    output logic [`XLEN-1:0]       csr_wdata,
    output sys_op_t                sys_op
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [`CSR_ADDR_W-1:0] FUNCT12_ECALL = 12'h000;
    localparam logic [`CSR_ADDR_W-1:0] FUNCT12_MRET  = 12'h302;

    logic alu_ok; // valid R or I alu encoding
    logic is_csr;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        wb_sel  = WB_ALU;
        sys_op  = SYS_ILLEGAL;
        alu_ok  = 1'b0;
        case (inst.r.opcode)
            OPC_OP: begin
                alu_ok = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_001: alu_op = ALU_SLL;
                    10'b0000000_010: alu_op = ALU_SLT;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_101: alu_op = ALU_SRL;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_111: alu_op = ALU_AND;
                    default:         alu_ok = 1'b0; // sra, sltu etc
                endcase
            end
            OPC_OP_IMM: begin
                alu_ok  = 1'b1;
                use_imm = 1'b1;
                case (inst.i.funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_ok = 1'b0; // immediate shifts not supported
                endcase
            end
            OPC_SYSTEM: begin
                wb_sel = WB_CSR;
                case (inst.i.funct3)
                    3'b001: sys_op = SYS_CSRRW;
                    3'b010: sys_op = SYS_CSRRS;
                    3'b000: begin
                        if (inst.i.rs1 == '0 && inst.i.rd == '0) begin
                            if (inst.i.imm12 == FUNCT12_ECALL)
                                sys_op = SYS_ECALL;
                            else if (inst.i.imm12 == FUNCT12_MRET)
                                sys_op = SYS_MRET;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        if (alu_ok)
            sys_op = SYS_NONE;
    end

    assign is_csr = (sys_op == SYS_CSRRW) || (sys_op == SYS_CSRRS);

    assign rs1      = inst.r.rs1;
    assign rs2      = inst.r.rs2;
    assign rd       = inst.r.rd;
    assign csr_addr = inst.i.imm12;
    assign imm      = {{(`XLEN-`CSR_ADDR_W){inst.i.imm12[`CSR_ADDR_W-1]}}, inst.i.imm12};

    assign rf_we_int  = alu_ok || is_csr;
    // csrrs with x0 only reads
    assign csr_we_int = (sys_op == SYS_CSRRW) ||
                        ((sys_op == SYS_CSRRS) && (inst.i.rs1 != '0));
    assign csr_wdata  = (sys_op == SYS_CSRRS) ? (csr_rdata | rs1_val) : rs1_val;

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

`include "core_params.svh"

module alu
    import rv_pkg::alu_op_t;
(
    input  alu_op_t          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);

    logic       lt;
    logic [4:0] shamt;

    assign lt    = $signed(a) < $signed(b);
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: y = a + b;
            rv_pkg::ALU_SUB: y = a - b;
            rv_pkg::ALU_AND: y = a & b;
            rv_pkg::ALU_OR:  y = a | b;
            rv_pkg::ALU_XOR: y = a ^ b;
            rv_pkg::ALU_SLT: y = {{(`XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_SLL: y = a << shamt;
            rv_pkg::ALU_SRL: y = a >> shamt; // logical only
            default:         y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

`include "core_params.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] imm12; // csr address on SYSTEM
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // one word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU, // rd gets alu result
        WB_CSR  // rd gets old csr value
    } wb_sel_t;

    typedef enum logic [2:0] {
        SYS_NONE,
        SYS_CSRRW,
        SYS_CSRRS,
        SYS_ECALL,
        SYS_MRET,
        SYS_ILLEGAL
    } sys_op_t;

endpackage

`default_nettype wire

/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

// machine csr map
`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MVENDORID  12'hf11
`define CSR_MARCHID    12'hf12

`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

`define CAUSE_ECALL_M  32'd11
`define CAUSE_ILLEGAL  32'd2

`define MVENDORID_VAL  32'h5256_3332 // "RV32" in ascii
`define MARCHID_VAL    32'h0000_0017

`endif
